// File: build.f
+incdir+include
+incdir+testbench
hdl/pixel_fmt_pkg.sv
hdl/p2b_csr_pkg.sv
hdl/p2b_csr.sv
hdl/raw_group_formatter.sv
hdl/pixel_format_router.sv
hdl/byte_word_packer.sv
hdl/word_aligner.sv
hdl/pixel2byte_top.sv
testbench/tb_pixel2byte.sv

// File: testbench/tb_tasks.svh
//------------------------------
// AXI4-Lite and pixel drivers,
// reference packing model and
// the directed tests
//------------------------------
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic axi_write(input logic [`P2B_AXI_AW-1:0] addr, input logic [31:0] data,
                         output logic [1:0] resp);
  @(posedge clk_csi);
  awaddr  <= addr;
  wdata   <= data;
  awvalid <= 1'b1;
  wvalid  <= 1'b1;
  @(negedge clk_csi);
  while (!(awready && wready)) begin
    @(negedge clk_csi);
  end
  @(posedge clk_csi);
  awvalid <= 1'b0;
  wvalid  <= 1'b0;
  bready  <= 1'b1;
  @(negedge clk_csi);
  while (!bvalid) begin
    @(negedge clk_csi);
  end
  resp = bresp;
  @(posedge clk_csi);
  bready <= 1'b0;
endtask

task automatic axi_read(input logic [`P2B_AXI_AW-1:0] addr, output logic [31:0] data,
                        output logic [1:0] resp);
  @(posedge clk_csi);
  araddr  <= addr;
  arvalid <= 1'b1;
  @(negedge clk_csi);
  while (!arready) begin
    @(negedge clk_csi);
  end
  @(posedge clk_csi);
  arvalid <= 1'b0;
  rready  <= 1'b1;
  @(negedge clk_csi);
  while (!rvalid) begin
    @(negedge clk_csi);
  end
  data = rdata;
  resp = rresp;
  @(posedge clk_csi);
  rready <= 1'b0;
endtask

// CTRL holds the format in bits 1:0 and the enable in bit 8
task automatic write_ctrl(input logic en, input logic [1:0] f);
  logic [1:0] resp;
  axi_write(`P2B_CTRL_ADDR, {23'd0, en, 6'd0, f}, resp);
  check_value("bresp", resp, 2'b00);
endtask

task automatic idle_cycles(input int n);
  repeat (n) @(posedge clk_csi);
endtask

// Reference packing: RAW8 is one byte per pixel, wider pixels form a
// group of MSB bytes followed by one byte of LSB fields
task automatic model_pixel(input logic [15:0] p, input int w);
  int         lsb_w;
  int         grp_n;
  logic [7:0] lsb_byte;
  if (w == 8) begin
    exp_bytes.push_back(p[7:0]);
  end else begin
    lsb_w = w - 8;
    grp_n = 8 / lsb_w;
    grp_pix.push_back(p);
    if (grp_pix.size() == grp_n) begin
      lsb_byte = '0;
      for (int i = 0; i < grp_n; i++) begin
        exp_bytes.push_back(8'((grp_pix[i] >> lsb_w) & 16'hff));
        lsb_byte = lsb_byte | 8'((grp_pix[i] & ((16'd1 << lsb_w) - 1)) << (i * lsb_w));
      end
      exp_bytes.push_back(lsb_byte);
      grp_pix.delete();
    end
  end
endtask

// One pixel per clock, keep low means the output must not carry them
task automatic send_pixels(input int n, input int w, input bit keep);
  logic [15:0] pix;
  for (int i = 0; i < n; i++) begin
    @(posedge clk_csi);
    pix = 16'($random(seed));
    pixel       <= pix;
    pixel_valid <= 1'b1;
    if (keep) begin
      model_pixel(pix, w);
    end
  end
  @(posedge clk_csi);
  pixel_valid <= 1'b0;
endtask

task automatic wait_for_beats(input int target);
  while (beats_seen < target) begin
    @(negedge clk_csi);
  end
  check_value("bytes left after beats", exp_bytes.size(), 0);
endtask

//------------------------------
// Directed tests
//------------------------------
task automatic test_registers();
  logic [31:0] data;
  logic [1:0]  resp;
  check_value("pixel_data64_valid", pixel_data64_valid, 1'b0);
  check_value("bvalid", bvalid, 1'b0);
  check_value("rvalid", rvalid, 1'b0);
  write_ctrl(1'b0, `P2B_FMT_RAW10);
  axi_read(`P2B_CTRL_ADDR, data, resp);
  check_value("CTRL", data, 32'h0000_0001);
  check_value("rresp", resp, 2'b00);
  axi_read(`P2B_STAT_ADDR, data, resp);
  check_value("STATUS", data, 32'd0);
  check_value("rresp", resp, 2'b00);
  // Address 8 is outside the register map
  axi_write(4'h8, 32'hffff_ffff, resp);
  check_value("bresp", resp, 2'b10);
  axi_read(4'h8, data, resp);
  check_value("rresp", resp, 2'b10);
  check_value("rdata", data, 32'd0);
  axi_read(`P2B_CTRL_ADDR, data, resp);
  check_value("CTRL", data, 32'h0000_0001);
endtask

task automatic test_raw8();
  write_ctrl(1'b1, `P2B_FMT_RAW8);
  send_pixels(16, 8, 1'b1);
  wait_for_beats(2);
endtask

task automatic test_raw10();
  write_ctrl(1'b1, `P2B_FMT_RAW10);
  send_pixels(32, 10, 1'b1);
  wait_for_beats(7);
endtask

task automatic test_raw12();
  write_ctrl(1'b0, `P2B_FMT_RAW10);
  write_ctrl(1'b0, `P2B_FMT_RAW12);
  write_ctrl(1'b1, `P2B_FMT_RAW12);
  send_pixels(16, 12, 1'b1);
  wait_for_beats(10);
endtask

task automatic test_stop_mode();
  logic [31:0] data;
  logic [1:0]  resp;
  write_ctrl(1'b1, `P2B_FMT_RAW8);
  send_pixels(8, 8, 1'b1);
  wait_for_beats(11);
  // Four pixels make one word that stop mode must drop
  send_pixels(4, 8, 1'b0);
  idle_cycles(PIPE_DEPTH);
  forcetxstopmode <= 1'b1;
  @(posedge clk_csi);
  forcetxstopmode <= 1'b0;
  send_pixels(8, 8, 1'b1);
  wait_for_beats(12);
  idle_cycles(4);
  axi_read(`P2B_STAT_ADDR, data, resp);
  // Two RAW8, five RAW10, three RAW12 and two stop mode beats
  check_value("STATUS", data, 32'd12);
  check_value("rresp", resp, 2'b00);
endtask

`endif

// File: testbench/tb_pixel2byte.sv
//------------------------------
// Pixel-to-byte testbench
// Clock, reset, DUT, beat monitor,
// checker and test sequence
//------------------------------
`timescale 1ns/10ps
`include "p2b_params.svh"

module tb_pixel2byte;

  // Tests take roughly 300 cycles, the limit leaves a wide margin
  localparam int EST_TEST_CYCLES = 300;
  localparam int TIMEOUT_CYCLES  = (EST_TEST_CYCLES * 20) / 3;
  // Router, packer and aligner each add one register stage
  localparam int PIPE_DEPTH      = 3;

  logic                   clk_csi;
  logic                   clk_csi_rst_n;
  logic                   forcetxstopmode;
  logic [`P2B_AXI_AW-1:0] awaddr;
  logic                   awvalid;
  logic                   awready;
  logic [31:0]            wdata;
  logic                   wvalid;
  logic                   wready;
  logic                   bvalid;
  logic                   bready;
  logic [1:0]             bresp;
  logic [`P2B_AXI_AW-1:0] araddr;
  logic                   arvalid;
  logic                   arready;
  logic                   rvalid;
  logic                   rready;
  logic [31:0]            rdata;
  logic [1:0]             rresp;
  logic [`P2B_PIX_W-1:0]  pixel;
  logic                   pixel_valid;
  logic [`P2B_BEAT_W-1:0] pixel_data64;
  logic                   pixel_data64_valid;

  integer                 seed;
  int                     cycle_cnt;
  int                     beats_seen;
  logic [7:0]             exp_bytes[$];
  logic [15:0]            grp_pix[$];
  logic [`P2B_BEAT_W-1:0] exp_beat;

  pixel2byte_top dut0 (.*);

  initial begin
    clk_csi = 1'b0;
    forever #10 clk_csi = ~clk_csi;
  end

  //------------------------------
  // Failure reporting
  //------------------------------
  task automatic stop_with_failure();
    $display("CHECKS FAILED");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  `include "tb_tasks.svh"

  // Beat monitor, earliest expected byte in bits 7:0
  always @(negedge clk_csi) begin
    if (clk_csi_rst_n && pixel_data64_valid) begin
      if (exp_bytes.size() < 8) begin
        $display("Beat at %0t arrived with no expected bytes left", $time);
        stop_with_failure();
      end
      for (int i = 0; i < 8; i++) begin
        exp_beat[i*8 +: 8] = exp_bytes.pop_front();
      end
      check_value("pixel_data64", pixel_data64, exp_beat);
      beats_seen++;
    end
  end

  always @(posedge clk_csi) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout, tests still running after %0d cycles", TIMEOUT_CYCLES);
      stop_with_failure();
    end
  end

  initial begin
    seed            = 96328;
    cycle_cnt       = 0;
    beats_seen      = 0;
    clk_csi_rst_n   = 1'b0;
    forcetxstopmode = 1'b0;
    awaddr          = '0;
    awvalid         = 1'b0;
    wdata           = '0;
    wvalid          = 1'b0;
    bready          = 1'b0;
    araddr          = '0;
    arvalid         = 1'b0;
    rready          = 1'b0;
    pixel           = '0;
    pixel_valid     = 1'b0;
    repeat (4) @(posedge clk_csi);
    clk_csi_rst_n <= 1'b1;

    test_registers();
    test_raw8();
    test_raw10();
    test_raw12();
    test_stop_mode();

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// File: hdl/pixel2byte_top.sv
//------------------------------
// CSI-2 pixel-to-byte top level
// Register block beside the
// RAW packing datapath
//------------------------------
`timescale 1ns/10ps
`include "p2b_params.svh"

module pixel2byte_top (
  input  logic                   clk_csi,
  input  logic                   clk_csi_rst_n,
  input  logic                   forcetxstopmode,
  input  logic [`P2B_AXI_AW-1:0] awaddr,
  input  logic                   awvalid,
  output logic                   awready,
  input  logic [31:0]            wdata,
  input  logic                   wvalid,
  output logic                   wready,
  output logic                   bvalid,
  input  logic                   bready,
  output logic [1:0]             bresp,
  input  logic [`P2B_AXI_AW-1:0] araddr,
  input  logic                   arvalid,
  output logic                   arready,
  output logic                   rvalid,
  input  logic                   rready,
  output logic [31:0]            rdata,
  output logic [1:0]             rresp,
  input  logic [`P2B_PIX_W-1:0]  pixel,
  input  logic                   pixel_valid,
  output logic [`P2B_BEAT_W-1:0] pixel_data64,
  output logic                   pixel_data64_valid
);
  import pixel_fmt_pkg::*;

  pix_fmt_e               fmt;
  logic                   enable;
  logic                   beat_pulse;
  byte_grp_t              grp_bytes;
  grp_len_t               grp_len;
  logic                   grp_valid;
  logic [`P2B_WORD_W-1:0] word;
  logic                   word_valid;

  p2b_csr u_csr (
    .clk_csi(clk_csi), .clk_csi_rst_n(clk_csi_rst_n),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wvalid(wvalid), .wready(wready),
    .bvalid(bvalid), .bready(bready), .bresp(bresp),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
    .beat_pulse(beat_pulse), .fmt(fmt), .enable(enable)
  );

  //------------------------------
  // Datapath
  //------------------------------
  pixel_format_router u_router (
    .clk_csi(clk_csi), .clk_csi_rst_n(clk_csi_rst_n),
    .fmt(fmt), .enable(enable),
    .pixel(pixel), .pixel_valid(pixel_valid),
    .grp_bytes(grp_bytes), .grp_len(grp_len), .grp_valid(grp_valid)
  );

  byte_word_packer u_packer (
    .clk_csi(clk_csi), .clk_csi_rst_n(clk_csi_rst_n), .enable(enable),
    .grp_bytes(grp_bytes), .grp_len(grp_len), .grp_valid(grp_valid),
    .word(word), .word_valid(word_valid)
  );

  word_aligner u_aligner (
    .clk_csi(clk_csi), .clk_csi_rst_n(clk_csi_rst_n),
    .enable(enable), .forcetxstopmode(forcetxstopmode),
    .word(word), .word_valid(word_valid),
    .pixel_data64(pixel_data64), .pixel_data64_valid(pixel_data64_valid),
    .beat_pulse(beat_pulse)
  );

endmodule

// File: hdl/word_aligner.sv
//------------------------------
// 32-to-64 word aligner
// Pairs words into beats and
// pulses once per beat
//------------------------------
`timescale 1ns/10ps
`include "p2b_params.svh"

module word_aligner (
  input  logic                   clk_csi,
  input  logic                   clk_csi_rst_n,
  input  logic                   enable,
  input  logic                   forcetxstopmode,
  input  logic [`P2B_WORD_W-1:0] word,
  input  logic                   word_valid,
  output logic [`P2B_BEAT_W-1:0] pixel_data64,
  output logic                   pixel_data64_valid,
  output logic                   beat_pulse
);

  logic [`P2B_WORD_W-1:0] low_word;
  logic                   half_pend;
  logic                   run;
  logic                   pair_done;

  assign run       = enable & ~forcetxstopmode;
  assign pair_done = run & word_valid & half_pend;

  // Stop mode or disable drops the pending half
  always_ff @(posedge clk_csi or negedge clk_csi_rst_n) begin
    if (!clk_csi_rst_n) begin
      half_pend          <= 1'b0;
      pixel_data64_valid <= 1'b0;
    end else if (!run) begin
      half_pend          <= 1'b0;
      pixel_data64_valid <= 1'b0;
    end else begin
      pixel_data64_valid <= pair_done;
      if (word_valid) begin
        half_pend <= ~half_pend;
      end
    end
  end

  // First word of the pair goes in the low half
  always_ff @(posedge clk_csi) begin
    if (run && word_valid && !half_pend) begin
      low_word <= word;
    end
    if (pair_done) begin
      pixel_data64 <= {word, low_word};
    end
  end

  assign beat_pulse = pixel_data64_valid;

endmodule

// File: hdl/byte_word_packer.sv
//------------------------------
// Byte to word packer
// Appends byte groups and emits
// the oldest four bytes per word
//------------------------------
`timescale 1ns/10ps
`include "p2b_params.svh"

module byte_word_packer (
  input  logic                     clk_csi,
  input  logic                     clk_csi_rst_n,
  input  logic                     enable,
  input  pixel_fmt_pkg::byte_grp_t grp_bytes,
  input  pixel_fmt_pkg::grp_len_t  grp_len,
  input  logic                     grp_valid,
  output logic [`P2B_WORD_W-1:0]   word,
  output logic                     word_valid
);
  import pixel_fmt_pkg::*;

  localparam int WORD_BYTES = `P2B_WORD_W / 8;
  localparam int ACC_BYTES  = 2 * WORD_BYTES;

  logic [ACC_BYTES*8-1:0] acc;
  logic [ACC_BYTES*8-1:0] merged;
  logic [3:0]             acc_cnt;
  logic [3:0]             tot;
  logic                   emit;

  // New bytes land right after the pending ones
  always_comb begin
    merged = acc;
    tot    = acc_cnt;
    if (grp_valid) begin
      for (int i = 0; i < `P2B_GRP_MAX; i++) begin
        if ((i < grp_len) && (acc_cnt + i < ACC_BYTES)) begin
          merged[(acc_cnt + i)*8 +: 8] = grp_bytes[i*8 +: 8];
        end
      end
      tot = acc_cnt + 4'(grp_len);
    end
  end

  assign emit = (tot >= 4'(WORD_BYTES));

  always_ff @(posedge clk_csi or negedge clk_csi_rst_n) begin
    if (!clk_csi_rst_n) begin
      acc_cnt    <= '0;
      word_valid <= 1'b0;
    end else if (!enable) begin
      acc_cnt    <= '0;
      word_valid <= 1'b0;
    end else begin
      acc_cnt    <= emit ? tot - 4'(WORD_BYTES) : tot;
      word_valid <= emit;
    end
  end

  // Earliest byte leaves in word bits 7:0
  always_ff @(posedge clk_csi) begin
    acc <= emit ? merged >> `P2B_WORD_W : merged;
    if (emit) begin
      word <= merged[`P2B_WORD_W-1:0];
    end
  end

  a_acc_no_overflow: assert property (@(posedge clk_csi) disable iff (!clk_csi_rst_n)
    grp_valid |-> (tot <= 4'(ACC_BYTES)));

endmodule

// File: hdl/pixel_format_router.sv
//------------------------------
// Pixel format router
// RAW8 byte path plus the RAW10
// and RAW12 group formatters
//------------------------------
`timescale 1ns/10ps
`include "p2b_params.svh"

module pixel_format_router (
  input  logic                     clk_csi,
  input  logic                     clk_csi_rst_n,
  input  pixel_fmt_pkg::pix_fmt_e  fmt,
  input  logic                     enable,
  input  logic [`P2B_PIX_W-1:0]    pixel,
  input  logic                     pixel_valid,
  output pixel_fmt_pkg::byte_grp_t grp_bytes,
  output pixel_fmt_pkg::grp_len_t  grp_len,
  output logic                     grp_valid
);
  import pixel_fmt_pkg::*;

  byte_grp_t r10_bytes;
  byte_grp_t r12_bytes;
  grp_len_t  r10_len;
  grp_len_t  r12_len;
  logic      r10_valid;
  logic      r12_valid;
  byte_grp_t sel_bytes;
  grp_len_t  sel_len;
  logic      sel_valid;

  raw_group_formatter #(.pix_t(raw10_pix_t)) u_raw10 (
    .clk_csi       (clk_csi),
    .clk_csi_rst_n (clk_csi_rst_n),
    .enable        (enable),
    .active        (fmt == RAW10),
    .pixel         (pixel[$bits(raw10_pix_t)-1:0]),
    .pixel_valid   (pixel_valid),
    .grp_bytes     (r10_bytes),
    .grp_len       (r10_len),
    .grp_valid     (r10_valid)
  );

  raw_group_formatter #(.pix_t(raw12_pix_t)) u_raw12 (
    .clk_csi       (clk_csi),
    .clk_csi_rst_n (clk_csi_rst_n),
    .enable        (enable),
    .active        (fmt == RAW12),
    .pixel         (pixel[$bits(raw12_pix_t)-1:0]),
    .pixel_valid   (pixel_valid),
    .grp_bytes     (r12_bytes),
    .grp_len       (r12_len),
    .grp_valid     (r12_valid)
  );

  // Active path select, RAW8 is one byte per pixel
  always_comb begin
    case (fmt)
      RAW8: begin
        sel_bytes = byte_grp_t'(pixel[7:0]);
        sel_len   = grp_len_t'(1);
        sel_valid = enable & pixel_valid;
      end
      RAW10: begin
        sel_bytes = r10_bytes;
        sel_len   = r10_len;
        sel_valid = r10_valid;
      end
      RAW12: begin
        sel_bytes = r12_bytes;
        sel_len   = r12_len;
        sel_valid = r12_valid;
      end
      default: begin
        sel_bytes = '0;
        sel_len   = '0;
        sel_valid = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_csi or negedge clk_csi_rst_n) begin
    if (!clk_csi_rst_n) begin
      grp_valid <= 1'b0;
    end else begin
      grp_valid <= sel_valid;
    end
  end

  always_ff @(posedge clk_csi) begin
    if (sel_valid) begin
      grp_bytes <= sel_bytes;
      grp_len   <= sel_len;
    end
  end

  // An empty group would stall the packer silently
  a_grp_len_nonzero: assert property (@(posedge clk_csi) disable iff (!clk_csi_rst_n)
    grp_valid |-> (grp_len != '0));

endmodule

// File: hdl/raw_group_formatter.sv
//------------------------------
// Wide RAW group formatter
// Collects a pixel group, emits
// MSB bytes then one LSB byte
//------------------------------
`timescale 1ns/10ps

module raw_group_formatter #(
  parameter type pix_t = pixel_fmt_pkg::raw10_pix_t
) (
  input  logic                     clk_csi,
  input  logic                     clk_csi_rst_n,
  input  logic                     enable,
  input  logic                     active,
  input  pix_t                     pixel,
  input  logic                     pixel_valid,
  output pixel_fmt_pkg::byte_grp_t grp_bytes,
  output pixel_fmt_pkg::grp_len_t  grp_len,
  output logic                     grp_valid
);
  import pixel_fmt_pkg::*;

  localparam int PIX_W   = $bits(pix_t);
  localparam int LSB_W   = PIX_W - 8;
  localparam int GRP_PIX = 8 / LSB_W;
  localparam int GRP_LEN = GRP_PIX + 1;
  localparam int CNT_W   = $clog2(GRP_PIX);
  localparam byte_grp_t GRP_MASK = byte_grp_t'((64'd1 << (GRP_LEN * 8)) - 64'd1);

  logic [CNT_W-1:0] pix_cnt;
  byte_grp_t        grp_stage;
  byte_grp_t        grp_next;
  logic             take;
  logic             last;

  assign take = enable & active & pixel_valid;
  assign last = (pix_cnt == CNT_W'(GRP_PIX - 1));

  // Pixel i gives MSB byte i and LSB field i of the last byte
  always_comb begin
    grp_next = grp_stage;
    grp_next[pix_cnt*8 +: 8] = pixel[PIX_W-1 -: 8];
    grp_next[GRP_PIX*8 + pix_cnt*LSB_W +: LSB_W] = pixel[LSB_W-1:0];
  end

  assign grp_bytes = grp_next & GRP_MASK;
  assign grp_len   = grp_len_t'(GRP_LEN);
  assign grp_valid = take & last;

  always_ff @(posedge clk_csi or negedge clk_csi_rst_n) begin
    if (!clk_csi_rst_n) begin
      pix_cnt <= '0;
    end else if (!enable || !active) begin
      pix_cnt <= '0;
    end else if (pixel_valid) begin
      pix_cnt <= last ? '0 : pix_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk_csi) begin
    if (take) begin
      grp_stage <= grp_next;
    end
  end

  // LSB fields of a whole group fill the trailing byte exactly
  a_lsb_fit: assert property (@(posedge clk_csi) disable iff (!clk_csi_rst_n)
    grp_valid |-> (LSB_W * GRP_PIX == 8));

endmodule

// File: hdl/p2b_csr.sv
//------------------------------
// AXI4-Lite register block
// CTRL holds format and enable,
// STATUS counts beats sent
//------------------------------
`timescale 1ns/10ps
`include "p2b_params.svh"

module p2b_csr (
  input  logic                     clk_csi,
  input  logic                     clk_csi_rst_n,
  input  logic [`P2B_AXI_AW-1:0]   awaddr,
  input  logic                     awvalid,
  output logic                     awready,
  input  logic [31:0]              wdata,
  input  logic                     wvalid,
  output logic                     wready,
  output logic                     bvalid,
  input  logic                     bready,
  output logic [1:0]               bresp,
  input  logic [`P2B_AXI_AW-1:0]   araddr,
  input  logic                     arvalid,
  output logic                     arready,
  output logic                     rvalid,
  input  logic                     rready,
  output logic [31:0]              rdata,
  output logic [1:0]               rresp,
  input  logic                     beat_pulse,
  output pixel_fmt_pkg::pix_fmt_e  fmt,
  output logic                     enable
);
  import pixel_fmt_pkg::*;
  import p2b_csr_pkg::*;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  ctrl_reg_t ctrl_q;
  beat_cnt_t beat_cnt;
  logic      wr_acc;
  logic      rd_acc;
  logic      wr_ok;
  logic      rd_ok;

  // One transaction per channel at a time
  assign wr_acc  = awvalid & wvalid & ~bvalid;
  assign rd_acc  = arvalid & ~rvalid;
  assign awready = wr_acc;
  assign wready  = wr_acc;
  assign arready = rd_acc;

  assign wr_ok = (awaddr == `P2B_CTRL_ADDR) | (awaddr == `P2B_STAT_ADDR);
  assign rd_ok = (araddr == `P2B_CTRL_ADDR) | (araddr == `P2B_STAT_ADDR);

  assign fmt    = pix_fmt_e'(ctrl_q.fmt);
  assign enable = ctrl_q.enable;

  //------------------------------
  // Write channel and CTRL
  //------------------------------
  always_ff @(posedge clk_csi or negedge clk_csi_rst_n) begin
    if (!clk_csi_rst_n) begin
      bvalid <= 1'b0;
      bresp  <= RESP_OKAY;
      ctrl_q <= '0;
    end else if (wr_acc) begin
      bvalid <= 1'b1;
      bresp  <= wr_ok ? RESP_OKAY : RESP_SLVERR;
      if (awaddr == `P2B_CTRL_ADDR) begin
        ctrl_q <= ctrl_reg_t'(wdata);
      end
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  //------------------------------
  // Read channel
  //------------------------------
  always_ff @(posedge clk_csi or negedge clk_csi_rst_n) begin
    if (!clk_csi_rst_n) begin
      rvalid <= 1'b0;
      rresp  <= RESP_OKAY;
    end else if (rd_acc) begin
      rvalid <= 1'b1;
      rresp  <= rd_ok ? RESP_OKAY : RESP_SLVERR;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk_csi) begin
    if (rd_acc) begin
      case (araddr)
        `P2B_CTRL_ADDR: rdata <= ctrl_q;
        `P2B_STAT_ADDR: rdata <= beat_cnt;
        default:        rdata <= '0;
      endcase
    end
  end

  // Beats sent since reset
  always_ff @(posedge clk_csi or negedge clk_csi_rst_n) begin
    if (!clk_csi_rst_n) begin
      beat_cnt <= '0;
    end else if (beat_pulse) begin
      beat_cnt <= beat_cnt + 1'b1;
    end
  end

  // A write response only follows an accepted write
  a_bvalid_after_write: assert property (@(posedge clk_csi) disable iff (!clk_csi_rst_n)
    $rose(bvalid) |-> $past(wr_acc));

endmodule

// File: hdl/p2b_csr_pkg.sv
//------------------------------
// Register field types for the
// pixel-to-byte control block
//------------------------------
package p2b_csr_pkg;

  // CTRL layout, format in 1:0 and enable in 8
  typedef struct packed {
    logic [22:0] rsvd_hi;
    logic        enable;
    logic [5:0]  rsvd_lo;
    logic [1:0]  fmt;
  } ctrl_reg_t;

  typedef logic [31:0] beat_cnt_t;

endpackage

// File: hdl/pixel_fmt_pkg.sv
//------------------------------
// Pixel format types
// Format select, RAW pixel types
// and the byte group carried
// from router to packer
//------------------------------
`include "p2b_params.svh"

package pixel_fmt_pkg;

  typedef enum logic [1:0] {
    RAW8  = `P2B_FMT_RAW8,
    RAW10 = `P2B_FMT_RAW10,
    RAW12 = `P2B_FMT_RAW12
  } pix_fmt_e;

  typedef logic [9:0]  raw10_pix_t;
  typedef logic [11:0] raw12_pix_t;

  // Byte 0 sits in bits 7:0
  typedef logic [8*`P2B_GRP_MAX-1:0] byte_grp_t;
  typedef logic [2:0]                grp_len_t;

endpackage

// File: include/p2b_params.svh
//------------------------------
// Pixel-to-byte packer constants
// Datapath widths, register map
// and pixel format codes
//------------------------------
`ifndef P2B_PARAMS_SVH
`define P2B_PARAMS_SVH

// Datapath widths
`define P2B_WORD_W    32
`define P2B_BEAT_W    64
`define P2B_PIX_W     16
`define P2B_GRP_MAX   5

// Register map
`define P2B_AXI_AW    4
`define P2B_CTRL_ADDR 4'h0
`define P2B_STAT_ADDR 4'h4

// Format codes held in CTRL[1:0]
`define P2B_FMT_RAW8  2'd0
`define P2B_FMT_RAW10 2'd1
`define P2B_FMT_RAW12 2'd2

`endif
